// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tbDekatronTop -f tb.f
	./obj_dir/VtbDekatronTop | tee /dev/stderr | grep "Simulation completed successfully" > /dev/null

clean:
	rm -rf obj_dir

// ==== sim/tbClock.sv ====
`timescale 1ns/1ns
`default_nettype none

module tbClock (
	output logic Clk,
	output logic Rst_n
);

	initial begin
		Clk = 1'b0;
		forever #5 Clk = ~Clk; // 10 ns period.
	end

	// reset stays low across the first four rising edges.
	initial begin
		Rst_n = 1'b0;
		repeat (4) @(posedge Clk);
		#1 Rst_n = 1'b1;
	end

endmodule

`default_nettype wire

// ==== sim/tbDekatronTop.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "dekatron_params.svh"

module tbDekatronTop
	import dekatronPkg::*;
();

	localparam int TimeoutCycles = 300 * (`DEK_STEP_CYCLES + 2) * 4;
	localparam int Modulus = 10 ** `DEK_DIGITS;

	logic Clk;
	logic Rst_n;
	logic cmdValid;
	logic cmdReady;
	dekCommand_t cmd;
	logic resValid;
	logic resReady;
	dekResult_t res;

	logic [31:0] lfsr = 32'h4ada9a5a;
	logic stallResults; // when set, resReady drops at random.
	int cycles = 0;
	int valueErrors = 0;
	int protocolErrors = 0;
	int cmdCount = 0;
	int resCount = 0;
	int modelValue = 0; // all glows start on cathode 0.
	dekResult_t expectQ[$];
	logic heldValid = 1'b0;
	dekResult_t heldRes;

	tbClock u_clock (
		.Clk(Clk),
		.Rst_n(Rst_n)
	);

	dekatronTop u_dekatronTop (
		.Clk(Clk),
		.Rst_n(Rst_n),
		.cmdValid(cmdValid),
		.cmdReady(cmdReady),
		.cmd(cmd),
		.resValid(resValid),
		.resReady(resReady),
		.res(res)
	);

	// x^32 + x^22 + x^2 + x + 1, one step per bit taken.
	function automatic int takeBits(input int count);
		int bits;
		logic fb;
		bits = 0;
		for (int i = 0; i < count; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			bits = (bits << 1) | int'(fb);
		end
		return bits;
	endfunction

	// nibbles above 9 have no cathode, so a tube loads them as 0.
	function automatic int bcdToInt(input counterValue_t v);
		int acc;
		bcdDigit_t nib;
		acc = 0;
		for (int d = `DEK_DIGITS - 1; d >= 0; d--) begin
			nib = v[4*d +: 4];
			acc = acc * 10 + ((nib > 4'd9) ? 0 : int'(nib));
		end
		return acc;
	endfunction

	function automatic counterValue_t intToBcd(input int n);
		counterValue_t v;
		int rest;
		rest = n;
		for (int d = 0; d < `DEK_DIGITS; d++) begin
			v[4*d +: 4] = bcdDigit_t'(rest % 10);
			rest = rest / 10;
		end
		return v;
	endfunction

	task automatic modelCommand(input dekCommand_t c);
		dekResult_t r;
		r.wrap = 1'b0;
		case (c.op)
			opInc: begin
				r.wrap = (modelValue == Modulus - 1);
				modelValue = (modelValue + 1) % Modulus;
			end
			opDec: begin
				r.wrap = (modelValue == 0);
				modelValue = (modelValue + Modulus - 1) % Modulus;
			end
			default: modelValue = bcdToInt(c.value);
		endcase
		r.value = intToBcd(modelValue);
		r.zero = (modelValue == 0);
		expectQ.push_back(r);
	endtask

	task automatic printCounts();
		$display("errors: %0d value, %0d protocol; %0d commands, %0d results",
			valueErrors, protocolErrors, cmdCount, resCount);
	endtask

	// Handshakes are sampled mid-cycle, where every signal is stable until the next edge.
	always @(negedge Clk) begin
		dekResult_t expected;
		if (Rst_n) begin
			if (heldValid) begin
				assert (resValid) else begin
					protocolErrors++;
					$display("resValid dropped while the result was stalled");
				end
				assert (res == heldRes) else begin
					valueErrors++;
					$display("CHECK FAILED res (stalled): got %h, expected %h", res, heldRes);
				end
			end
			heldValid = resValid && !resReady;
			heldRes = res;
			if (cmdValid && cmdReady) begin
				modelCommand(cmd);
				cmdCount++;
			end
			if (resValid && resReady) begin
				resCount++;
				assert (expectQ.size() > 0) else begin
					protocolErrors++;
					$display("a result was returned with no command outstanding");
				end
				if (expectQ.size() > 0) begin
					expected = expectQ.pop_front();
					assert (res.value == expected.value) else begin
						valueErrors++;
						$display("CHECK FAILED res.value: got %h, expected %h",
							res.value, expected.value);
					end
					assert (res.zero == expected.zero) else begin
						valueErrors++;
						$display("CHECK FAILED res.zero: got %h, expected %h",
							res.zero, expected.zero);
					end
					assert (res.wrap == expected.wrap) else begin
						valueErrors++;
						$display("CHECK FAILED res.wrap: got %h, expected %h",
							res.wrap, expected.wrap);
					end
				end
			end
		end
	end

	always @(posedge Clk) begin
		cycles <= cycles + 1;
		if (cycles >= TimeoutCycles) begin
			$display("timeout after %0d cycles, the DUT stopped making progress", cycles);
			printCounts();
			$display("Simulation failed");
			$finish;
		end
	end

	task automatic nextCycle();
		@(posedge Clk);
		#1;
		if (stallResults) resReady = (takeBits(2) != 0); // low about one cycle in four.
		else resReady = 1'b1;
	endtask

	task automatic sendCommand(input dekOp_t op, input counterValue_t value);
		logic accepted;
		cmd.op = op;
		cmd.value = value;
		cmdValid = 1'b1;
		accepted = 1'b0;
		while (!accepted) begin
			@(negedge Clk);
			accepted = cmdReady;
			nextCycle();
		end
		cmdValid = 1'b0;
	endtask

	task automatic drainResults();
		while (resCount != cmdCount) nextCycle();
	endtask

	// counts edges from the command transfer up to the one that raises resValid.
	task automatic measureLatency(input dekOp_t op, input counterValue_t value);
		int latency;
		logic seen;
		drainResults();
		sendCommand(op, value);
		latency = 0;
		seen = 1'b0;
		while (!seen) begin
			@(negedge Clk);
			seen = resValid;
			if (!seen) latency++;
			nextCycle();
		end
		assert (latency == `DEK_STEP_CYCLES + 1) else begin
			valueErrors++;
			$display("CHECK FAILED resValid latency: got %h, expected %h",
				latency, `DEK_STEP_CYCLES + 1);
		end
	endtask

	initial begin
		int gap;
		int pick;
		dekOp_t op;
		counterValue_t value;
		cmdValid = 1'b0;
		cmd = '0;
		resReady = 1'b0;
		stallResults = 1'b0;
		wait (Rst_n);
		@(negedge Clk);
		assert (cmdReady) else begin
			valueErrors++;
			$display("CHECK FAILED cmdReady after reset: got %h, expected 1", cmdReady);
		end
		assert (!resValid) else begin
			valueErrors++;
			$display("CHECK FAILED resValid after reset: got %h, expected 0", resValid);
		end
		nextCycle();

		// corner cases: first count, carry ripple and both wraps.
		sendCommand(opInc, '0);
		sendCommand(opSet, counterValue_t'('h999));
		sendCommand(opInc, '0);
		sendCommand(opSet, '0);
		sendCommand(opDec, '0);
		sendCommand(opInc, '0);

		measureLatency(opInc, '0);
		measureLatency(opDec, '0);
		measureLatency(opSet, counterValue_t'('h123456));

		stallResults = 1'b1;
		for (int n = 0; n < 300; n++) begin
			gap = takeBits(2);
			repeat (gap) nextCycle();
			pick = takeBits(2);
			for (int d = 0; d < `DEK_DIGITS; d++) begin
				value[4*d +: 4] = bcdDigit_t'(takeBits(4));
			end
			case (pick)
				1: op = opDec;
				2: op = opSet;
				default: op = opInc;
			endcase
			sendCommand(op, value);
		end
		stallResults = 1'b0;
		drainResults();

		// a spare result would show up within two step times.
		repeat (2 * (`DEK_STEP_CYCLES + 2)) nextCycle();
		assert (resCount == cmdCount && expectQ.size() == 0) else begin
			protocolErrors++;
			$display("%0d results were returned for %0d commands", resCount, cmdCount);
		end
		assert (!resValid) else begin
			protocolErrors++;
			$display("resValid is still high after every result was taken");
		end

		printCounts();
		if (valueErrors == 0 && protocolErrors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== source/dekatronCommandPort.sv ====
`timescale 1ns/1ns
`default_nettype none

module dekatronCommandPort
	import dekatronPkg::*;
(
	input logic Clk,
	input logic Rst_n,
	input logic cmdValid,
	output logic cmdReady,
	input dekCommand_t cmd,
	output logic bufValid,
	output dekCommand_t bufCmd,
	input logic start
);

	logic take;

	// a command taken by start frees the slot in the same cycle.
	assign cmdReady = !bufValid || start;
	assign take = cmdValid && cmdReady;

	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n) begin
			bufValid <= 1'b0;
		end else if (take) begin
			bufValid <= 1'b1; // refilled, even when start empties it now.
		end else if (start) begin
			bufValid <= 1'b0;
		end
	end

	// The held command waits here while the previous one is still stepping.
	always_ff @(posedge Clk) begin
		if (take) begin
			bufCmd <= cmd;
		end
	end

endmodule

`default_nettype wire

// ==== source/dekatronCounter.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "dekatron_params.svh"

module dekatronCounter
	import dekatronPkg::*;
(
	input logic Clk,
	input logic Rst_n,
	input logic bufValid,
	input dekCommand_t bufCmd,
	output logic start,
	input logic resultFree,
	output logic doneValid,
	output cathodes_t [`DEK_DIGITS-1:0] glows,
	output logic wrapOut
);

	dekOp_t curOp;
	counterValue_t curValue;
	logic busy; // from start until the result is handed over.
	logic pending; // step finished but the result port was full.
	guidePulse_t senderPulses;
	logic senderLoad;
	logic senderDone;
	logic down;
	guidePulse_t [`DEK_DIGITS:0] chainPulses;
	logic [`DEK_DIGITS-1:0] carryHigh;
	logic [`DEK_DIGITS-1:0] carryLow;

	assign doneValid = (senderDone || pending) && resultFree;
	assign start = (!busy || doneValid) && bufValid && resultFree;
	assign down = (curOp == opDec);

	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n) begin
			busy <= 1'b0;
			pending <= 1'b0;
			curOp <= opInc;
			wrapOut <= 1'b0;
		end else begin
			if (start) begin
				busy <= 1'b1;
				curOp <= bufCmd.op;
			end else if (doneValid) begin
				busy <= 1'b0;
			end
			if (senderDone && !resultFree) pending <= 1'b1;
			else if (resultFree) pending <= 1'b0;
			if (start) wrapOut <= 1'b0;
			else if (chainPulses[`DEK_DIGITS] != '0) wrapOut <= 1'b1;
		end
	end

	always_ff @(posedge Clk) begin
		if (start) curValue <= bufCmd.value;
	end

	dekatronPulseSender u_pulseSender (
		.Clk(Clk),
		.Rst_n(Rst_n),
		.go(start),
		.setOp(curOp == opSet),
		.pulses(senderPulses),
		.load(senderLoad),
		.done(senderDone)
	);

	assign chainPulses[0] = senderPulses;

	for (genvar d = 0; d < `DEK_DIGITS; d++) begin : gTube
		dekatronTube u_tube (
			.Clk(Clk),
			.Rst_n(Rst_n),
			.load(senderLoad),
			.loadDigit(curValue[4*d +: 4]),
			.pulses(chainPulses[d]),
			.down(down),
			.glow(glows[d]),
			.carryHigh(carryHigh[d]),
			.carryLow(carryLow[d])
		);

		// a tube passes the pulse on only from 9 going up or from 0 going down.
		assign chainPulses[d+1] = (down ? carryLow[d] : carryHigh[d]) ? chainPulses[d] : '0;
	end

endmodule

`default_nettype wire

// ==== source/dekatronPkg.sv ====
`default_nettype none

package dekatronPkg;
	`include "dekatron_params.svh"

	typedef logic [3:0] bcdDigit_t; // one decimal digit.
	typedef logic [9:0] cathodes_t; // one-hot glow, bit n is cathode n.
	typedef logic [4*`DEK_DIGITS-1:0] counterValue_t; // digit 0 in the lowest nibble.
	typedef logic [1:0] guidePulse_t; // bit 0 is the first guide phase.

	typedef enum logic [1:0] {
		opInc,
		opDec,
		opSet
	} dekOp_t;

	typedef struct packed {
		dekOp_t op;
		counterValue_t value; // only meaningful for opSet.
	} dekCommand_t;

	typedef struct packed {
		counterValue_t value;
		logic zero;
		logic wrap; // the pulse ran off the last tube.
	} dekResult_t;

	typedef enum logic [1:0] {
		idle,
		phaseA,
		phaseB,
		settle
	} senderState_t;
endpackage

`default_nettype wire

// ==== source/dekatronPulseSender.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "dekatron_params.svh"

module dekatronPulseSender
	import dekatronPkg::*;
(
	input logic Clk,
	input logic Rst_n,
	input logic go,
	input logic setOp,
	output guidePulse_t pulses,
	output logic load,
	output logic done
);

	localparam int CntW = $clog2(`DEK_STEP_CYCLES + 1);

	senderState_t state;
	logic [CntW-1:0] settleCnt; // settle cycles still to wait after this one.

	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n) begin
			state <= idle;
			settleCnt <= '0;
		end else begin
			case (state)
				idle: begin
					if (go) state <= phaseA;
				end
				phaseA: state <= phaseB;
				phaseB: begin
					state <= settle;
					settleCnt <= CntW'(`DEK_STEP_CYCLES - 3); // two phases plus the done cycle.
				end
				settle: begin
					if (settleCnt == '0) begin
						state <= go ? phaseA : idle; // back to back steps.
					end else begin
						settleCnt <= settleCnt - 1'b1;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// A set loads the rings in the first step cycle and sends no guide pulses.
	always_comb begin
		pulses = '0;
		if (!setOp) begin
			pulses[0] = (state == phaseA);
			pulses[1] = (state == phaseB);
		end
	end

	assign load = (state == phaseA) && setOp;
	assign done = (state == settle) && (settleCnt == '0);

endmodule

`default_nettype wire

// ==== source/dekatronResultPort.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "dekatron_params.svh"

module dekatronResultPort
	import dekatronPkg::*;
(
	input logic Clk,
	input logic Rst_n,
	input logic doneValid,
	input cathodes_t [`DEK_DIGITS-1:0] glows,
	input logic wrapIn,
	output logic resultFree,
	output logic resValid,
	input logic resReady,
	output dekResult_t res
);

	counterValue_t decoded;

	function automatic bcdDigit_t glowToBcd(input cathodes_t glow);
		bcdDigit_t digit;
		digit = '0;
		for (int i = 0; i < 10; i++) begin
			if (glow[i]) digit = bcdDigit_t'(i);
		end
		return digit;
	endfunction

	always_comb begin
		for (int d = 0; d < `DEK_DIGITS; d++) begin
			decoded[4*d +: 4] = glowToBcd(glows[d]);
		end
	end

	assign resultFree = !resValid || resReady; // empty, or emptied this cycle.

	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n) begin
			resValid <= 1'b0;
		end else if (doneValid) begin
			resValid <= 1'b1;
		end else if (resReady) begin
			resValid <= 1'b0;
		end
	end

	always_ff @(posedge Clk) begin
		if (doneValid) begin
			res.value <= decoded;
			res.zero <= (decoded == '0);
			res.wrap <= wrapIn;
		end
	end

endmodule

`default_nettype wire

// ==== source/dekatronTop.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "dekatron_params.svh"

module dekatronTop
	import dekatronPkg::*;
(
	input logic Clk,
	input logic Rst_n,
	input logic cmdValid,
	output logic cmdReady,
	input dekCommand_t cmd,
	output logic resValid,
	input logic resReady,
	output dekResult_t res
);

	logic bufValid;
	dekCommand_t bufCmd;
	logic start;
	logic resultFree;
	logic doneValid;
	logic wrap;
	cathodes_t [`DEK_DIGITS-1:0] glows;

	dekatronCommandPort u_commandPort (
		.Clk(Clk),
		.Rst_n(Rst_n),
		.cmdValid(cmdValid),
		.cmdReady(cmdReady),
		.cmd(cmd),
		.bufValid(bufValid),
		.bufCmd(bufCmd),
		.start(start)
	);

	dekatronCounter u_counter (
		.Clk(Clk),
		.Rst_n(Rst_n),
		.bufValid(bufValid),
		.bufCmd(bufCmd),
		.start(start),
		.resultFree(resultFree),
		.doneValid(doneValid),
		.glows(glows),
		.wrapOut(wrap)
	);

	dekatronResultPort u_resultPort (
		.Clk(Clk),
		.Rst_n(Rst_n),
		.doneValid(doneValid),
		.glows(glows),
		.wrapIn(wrap),
		.resultFree(resultFree),
		.resValid(resValid),
		.resReady(resReady),
		.res(res)
	);

endmodule

`default_nettype wire

// ==== source/dekatronTube.sv ====
`timescale 1ns/1ns
`default_nettype none

module dekatronTube
	import dekatronPkg::*;
(
	input logic Clk,
	input logic Rst_n,
	input logic load,
	input bcdDigit_t loadDigit,
	input guidePulse_t pulses,
	input logic down,
	output cathodes_t glow,
	output logic carryHigh,
	output logic carryLow
);

	logic guide; // glow is parked on the guide electrodes between phases.
	cathodes_t loadGlow;
	cathodes_t stepGlow;

	// Digits above 9 have no cathode and fall back to 0.
	always_comb begin
		if (loadDigit > 4'd9) begin
			loadGlow = cathodes_t'(1);
		end else begin
			loadGlow = cathodes_t'(1) << loadDigit;
		end
	end

	// one cathode along the ring in the counting direction.
	always_comb begin
		if (down) begin
			stepGlow = {glow[0], glow[9:1]};
		end else begin
			stepGlow = {glow[8:0], glow[9]};
		end
	end

	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n) begin
			glow <= cathodes_t'(1);
			guide <= 1'b0;
		end else if (load) begin
			glow <= loadGlow;
			guide <= 1'b0;
		end else if (pulses[0]) begin
			guide <= 1'b1; // first phase pulls the glow off its cathode.
		end else if (pulses[1] && guide) begin
			glow <= stepGlow; // second phase lands it on the neighbour.
			guide <= 1'b0;
		end
	end

	// glow only changes at the end of phase B, so these show the position before the step.
	assign carryHigh = glow[9];
	assign carryLow = glow[0];

endmodule

`default_nettype wire

// ==== source/dekatron_params.svh ====
`ifndef DEKATRON_PARAMS_SVH
`define DEKATRON_PARAMS_SVH

// number of tubes in the chain, one decimal digit each.
`define DEK_DIGITS 6

// clock cycles from the start of a step to its done strobe.
// Phase A and phase B take two of them, so the value must be at least 3.
`define DEK_STEP_CYCLES 3

`endif

// ==== tb.f ====
+incdir+source
source/dekatronPkg.sv
source/dekatronCommandPort.sv
source/dekatronPulseSender.sv
source/dekatronTube.sv
source/dekatronCounter.sv
source/dekatronResultPort.sv
source/dekatronTop.sv
sim/tbClock.sv
sim/tbDekatronTop.sv
